/* files.f */
adc_capture_pkg.sv
adc_lane_deserializer.sv
adc_word_fifo.sv
adc_capture_top.sv
tb_clock_gen.sv
adc_capture_tb.sv

/* Bender.yml */
package:
  name: adc_capture

sources:
  - adc_capture_pkg.sv
  - adc_lane_deserializer.sv
  - adc_word_fifo.sv
  - adc_capture_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - adc_capture_tb.sv

/* adc_capture_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module adc_capture_tb import adc_capture_pkg::*; ();

  localparam int RESET_CYCLES = 8;
  localparam int NUM_TESTS    = 6;

  // one row per test
  typedef struct {
    string name;
    int    n_words;     // words to check
    int    sync_mode;   // 0 none, 1 random, 2 one slot per word
    int    ovr_mode;    // 0 none, 1 random, 2 fixed four-word pattern
    int    hold_words;  // user_ready low for this many word times
    bit    expect_ovf;
    bit    apply_reset;
  } test_row_t;

  // what the checker knows about each model word
  typedef struct {
    int         idx;
    int         sync_mode;
    int         ovr_mode;
    overrange_t ovr_pat;
  } word_meta_t;

  logic      adc_clk;
  logic      por_reset;
  logic      tb_reset;
  logic      dcm_reset;
  logic      ctrl_reset;
  adc_pins_s pins;
  logic      adc_rst;
  adc_word_s user_word;
  logic      user_valid;
  logic      user_ready;
  logic      user_overflow;

  test_row_t  tests [NUM_TESTS];
  adc_word_s  exp_q [$];  // model words in order
  word_meta_t meta_q [$];

  logic [31:0] lfsr = 32'h41f2_f33b;
  adc_word_s   model_word;      // word being built by the driver
  word_meta_t  cur_meta;
  int cyc         = 0;
  int drv_slot    = 0;
  int next_idx    = 0;          // index of the next word to start
  int rst_left    = 0;
  int ready_hold  = 0;          // cycles left with ready low
  int sync_mode   = 1;
  int ovr_mode    = 1;
  int mode_base   = 0;
  int test_start  = 0;
  int got         = 0;          // words of this test read
  int errors      = 0;
  int tests_fail  = 0;
  bit check_en    = 1'b1;

  assign dcm_reset = por_reset | tb_reset;

  tb_clock_gen #(.PERIOD(100.0), .RESET_CYCLES(RESET_CYCLES)) tb_clock_gen_i (
    .adc_clk   (adc_clk),
    .dcm_reset (por_reset)
  );

  adc_capture_top #(.EXTRA_REG(1)) adc_capture_top_i (
    .adc_clk       (adc_clk),
    .dcm_reset     (dcm_reset),
    .ctrl_reset    (ctrl_reset),
    .pins          (pins),
    .adc_rst       (adc_rst),
    .user_word     (user_word),
    .user_valid    (user_valid),
    .user_ready    (user_ready),
    .user_overflow (user_overflow)
  );

  // --------------------------------------------------
  // random bits
  // --------------------------------------------------

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  // --------------------------------------------------
  // per-cycle pin driver, model and read check
  // --------------------------------------------------

  task automatic check_read();
    adc_word_s  exp;
    word_meta_t m;
    if (exp_q.size() == 0) begin
      $display("ERROR %0t: DUT delivered a word the model never built", $time);
      errors++;
      return;
    end
    exp = exp_q.pop_front();
    m   = meta_q.pop_front();
    assert (user_word === exp) else begin
      $display("FAIL %0t user_word exp %h got %h", $time, exp, user_word);
      errors++;
    end
    if (m.sync_mode == 2) begin  // one slot rotating with the word index
      assert (user_word.sync === sync_slots_t'(1 << (m.idx % SLOTS_PER_WORD))) else begin
        $display("FAIL %0t user_word.sync exp %b got %b", $time,
                 sync_slots_t'(1 << (m.idx % SLOTS_PER_WORD)), user_word.sync);
        errors++;
      end
    end
    if (m.ovr_mode == 2) begin
      assert (user_word.overrange === m.ovr_pat) else begin
        $display("FAIL %0t user_word.overrange exp %b got %b", $time,
                 m.ovr_pat, user_word.overrange);
        errors++;
      end
    end
    if (m.idx >= test_start) got++;
  endtask

  task automatic drive_pins();
    logic [31:0] r;
    logic        s;
    logic        o;
    int          k;
    if (drv_slot == 0) begin  // modes latched per word
      cur_meta.idx       = next_idx;
      cur_meta.sync_mode = sync_mode;
      cur_meta.ovr_mode  = ovr_mode;
      k = (next_idx - mode_base) % 4;
      case (k)
        0:       cur_meta.ovr_pat = 2'b01;
        1:       cur_meta.ovr_pat = 2'b10;
        2:       cur_meta.ovr_pat = 2'b11;
        default: cur_meta.ovr_pat = 2'b00;
      endcase
      next_idx++;
    end
    take_bits(32, r);
    pins.di_d = r[7:0];
    pins.di   = r[15:8];
    pins.dq_d = r[23:16];
    pins.dq   = r[31:24];
    take_bits(1, r);
    case (cur_meta.sync_mode)
      1:       s = r[0];
      2:       s = (drv_slot == cur_meta.idx % SLOTS_PER_WORD);
      default: s = 1'b0;
    endcase
    take_bits(1, r);
    case (cur_meta.ovr_mode)
      1:       o = r[0];
      2:       o = (drv_slot == 1 && cur_meta.ovr_pat[0]) ||
                   (drv_slot == 3 && cur_meta.ovr_pat[1]);
      default: o = 1'b0;
    endcase
    pins.sync      = s;
    pins.overrange = o;
    // model word with slot 0 in the low byte of each lane
    if (drv_slot == 0) model_word.overrange = '0;
    model_word.di_d[drv_slot*SAMPLE_W +: SAMPLE_W] = pins.di_d;
    model_word.di[drv_slot*SAMPLE_W +: SAMPLE_W]   = pins.di;
    model_word.dq_d[drv_slot*SAMPLE_W +: SAMPLE_W] = pins.dq_d;
    model_word.dq[drv_slot*SAMPLE_W +: SAMPLE_W]   = pins.dq;
    model_word.sync[drv_slot] = s;
    if (o) model_word.overrange[drv_slot / 2] = 1'b1;  // halves 0/1 and 2/3
    if (drv_slot == SLOTS_PER_WORD - 1) begin
      exp_q.push_back(model_word);
      meta_q.push_back(cur_meta);
      drv_slot = 0;
    end else begin
      drv_slot++;
    end
  endtask

  task automatic cycle();
    @(posedge adc_clk);
    #10;
    cyc++;
    if (rst_left > 0) begin
      tb_reset = 1'b1;
      rst_left--;
    end else begin
      tb_reset = 1'b0;
    end
    user_ready = (ready_hold == 0);
    if (ready_hold > 0) ready_hold--;
    if (cyc < RESET_CYCLES || tb_reset) begin  // pins of this cycle are never used
      pins     = '0;
      drv_slot = 0;
      exp_q.delete();
      meta_q.delete();
    end else begin
      drive_pins();
    end
    // no transfer while reset is applied at the next edge
    if (check_en && !tb_reset && user_valid && user_ready) check_read();
  endtask

  // --------------------------------------------------
  // one table row
  // --------------------------------------------------

  task automatic run_test(input int t);
    test_row_t row;
    int        err_before;
    int        limit;
    int        n;
    int        first_idx;
    row = tests[t];
    err_before = errors;
    first_idx  = next_idx;
    sync_mode  = row.sync_mode;
    ovr_mode   = row.ovr_mode;
    if (row.apply_reset) begin
      first_idx = next_idx;  // next word built is the first after reset
      rst_left = 2;
      n = 0;
      while ((rst_left > 0 || cyc < RESET_CYCLES) && n < 100) begin
        cycle();
        n++;
      end
      if (n >= 100) begin
        $display("ERROR %0t: reset sequence did not finish", $time);
        errors++;
      end
      cycle();
      check_en = 1'b1;
      assert (user_valid === 1'b0) else begin
        $display("FAIL %0t user_valid exp 0 got %b", $time, user_valid);
        errors++;
      end
      assert (user_overflow === 1'b0) else begin
        $display("FAIL %0t user_overflow exp 0 got %b", $time, user_overflow);
        errors++;
      end
      for (int i = 0; i < 3; i++) begin  // adc_rst pass-through
        ctrl_reset = ~ctrl_reset;
        #1;
        assert (adc_rst === ctrl_reset) else begin
          $display("FAIL %0t adc_rst exp %b got %b", $time, ctrl_reset, adc_rst);
          errors++;
        end
        cycle();
      end
    end
    mode_base  = next_idx;
    if (row.apply_reset) begin
      test_start = first_idx;
    end else begin
      test_start = next_idx;
    end
    got        = 0;
    ready_hold = row.hold_words * SLOTS_PER_WORD;
    limit = (row.n_words + row.hold_words + 10) * SLOTS_PER_WORD * 2;
    n = 0;
    while (got < row.n_words && n < limit) begin
      cycle();
      n++;
    end
    if (got < row.n_words) begin
      $display("ERROR %0t: timed out with %0d of %0d words read", $time, got, row.n_words);
      errors++;
    end
    assert (user_overflow === row.expect_ovf) else begin
      $display("FAIL %0t user_overflow exp %b got %b", $time, row.expect_ovf, user_overflow);
      errors++;
    end
    if (row.expect_ovf) begin  // lost words leave the model behind so park until reset
      check_en   = 1'b0;
      ready_hold = 1_000_000;
    end
    if (errors == err_before) begin
      $display("test %0d %s: ok, %0d words", t + 1, row.name, got);
    end else begin
      $display("test %0d %s: %0d errors", t + 1, row.name, errors - err_before);
      tests_fail++;
    end
  endtask

  initial begin
    tb_reset   = 1'b0;
    ctrl_reset = 1'b0;
    pins       = '0;
    user_ready = 1'b1;
    //                name           n   sync ovr hold ovf rst
    tests[0] = '{"ordering",      8,  1,   1,  0,   0,  1};
    tests[1] = '{"sync capture",  8,  2,   0,  0,   0,  0};
    tests[2] = '{"overrange",     8,  0,   2,  0,   0,  0};
    tests[3] = '{"back-pressure", 10, 1,   1,  10,  0,  0};
    tests[4] = '{"overflow",      16, 1,   1,  24,  1,  1};
    tests[5] = '{"reset",         8,  1,   1,  0,   0,  1};
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_fail, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// testbench clock and power-on reset
module tb_clock_gen #(
  parameter realtime PERIOD       = 100.0,
  parameter int      RESET_CYCLES = 8
) (
  output logic adc_clk,
  output logic dcm_reset
);

  initial begin
    adc_clk = 1'b0;
    forever #(PERIOD / 2.0) adc_clk = ~adc_clk;
  end

  // released 10 ns after the last reset edge, like every other input
  initial begin
    dcm_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    #10 dcm_reset = 1'b0;
  end

endmodule

`default_nettype wire

/* adc_capture_top.sv */
`timescale 1ns/10ps
`default_nettype none

// adc capture top
// pins -> input register -> deserializer -> (extra reg) -> word fifo -> user
module adc_capture_top import adc_capture_pkg::*; #(
  parameter int EXTRA_REG = 1  // 1 adds a register before the fifo for timing
) (
  input  wire logic      adc_clk,
  input  wire logic      dcm_reset,
  input  wire logic      ctrl_reset,
  input  wire adc_pins_s pins,
  output logic           adc_rst,
  // user port
  output adc_word_s      user_word,
  output logic           user_valid,
  input  wire logic      user_ready,
  output logic           user_overflow
);

  adc_pins_s pin_sample;  // pins one cycle late
  logic      pin_valid;

  adc_word_s word;        // from the deserializer
  logic      word_valid;

  adc_word_s fifo_word;   // into the fifo
  logic      fifo_valid;

  // --------------------------------------------------
  // input register
  // --------------------------------------------------

  always_ff @(posedge adc_clk) begin
    pin_sample <= pins;  // every cycle
  end

  // first sample after reset is slot 0
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      pin_valid <= 1'b0;
    end else begin
      pin_valid <= 1'b1;
    end
  end

  adc_lane_deserializer adc_lane_deserializer_i (
    .adc_clk    (adc_clk),
    .dcm_reset  (dcm_reset),
    .pin_sample (pin_sample),
    .pin_valid  (pin_valid),
    .word       (word),
    .word_valid (word_valid)
  );

  // --------------------------------------------------
  // optional register stage
  // --------------------------------------------------

  if (EXTRA_REG != 0) begin : g_extra_reg
    always_ff @(posedge adc_clk) begin
      fifo_word <= word;  // payload
      if (dcm_reset) begin
        fifo_valid <= 1'b0;
      end else begin
        fifo_valid <= word_valid;
      end
    end
  end else begin : g_no_extra_reg
    assign fifo_word  = word;
    assign fifo_valid = word_valid;
  end

  adc_word_fifo adc_word_fifo_i (
    .adc_clk   (adc_clk),
    .dcm_reset (dcm_reset),
    .wr_word   (fifo_word),
    .wr_valid  (fifo_valid),
    .rd_word   (user_word),
    .rd_valid  (user_valid),
    .rd_ready  (user_ready),
    .overflow  (user_overflow)
  );

  assign adc_rst = ctrl_reset;  // adc reset pin straight from control

endmodule

`default_nettype wire

/* adc_word_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

// synchronous word fifo with the head word shown directly on rd_word
// write side has no back-pressure, a full fifo drops and flags overflow
module adc_word_fifo import adc_capture_pkg::*; (
  input  wire logic      adc_clk,
  input  wire logic      dcm_reset,
  // write side, valid only
  input  wire adc_word_s wr_word,
  input  wire logic      wr_valid,
  // read side, valid/ready
  output adc_word_s      rd_word,
  output logic           rd_valid,
  input  wire logic      rd_ready,
  // sticky until reset
  output logic           overflow
);

  localparam fifo_count_t COUNT_FULL = fifo_count_t'(FIFO_DEPTH);

  adc_word_s   mem [FIFO_DEPTH];  // storage, no reset

  fifo_addr_t  wr_ptr;
  fifo_addr_t  rd_ptr;
  fifo_count_t count;             // words stored

  logic empty;
  logic full;
  logic pop;                      // head word taken this edge
  logic push;                     // incoming word stored this edge
  logic drop;                     // incoming word lost

  // --------------------------------------------------
  // flags and handshake
  // --------------------------------------------------

  assign empty = (count == '0);
  assign full  = (count == COUNT_FULL);

  assign pop  = rd_valid & rd_ready;
  assign push = wr_valid & (~full | pop);  // a read frees its place on the same edge
  assign drop = wr_valid & full & ~pop;

  assign rd_valid = ~empty;        // fall-through
  assign rd_word  = mem[rd_ptr];   // head word

  // --------------------------------------------------
  // storage
  // --------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  // --------------------------------------------------
  // pointers and fill count
  // --------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or both on the same edge
      endcase
    end
  end

  // lost words are not counted, only flagged
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      overflow <= 1'b0;
    end else if (drop) begin
      overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* adc_lane_deserializer.sv */
`timescale 1ns/10ps
`default_nettype none

// gathers SLOTS_PER_WORD consecutive samples of every lane into one word
// word_valid pulses the cycle after the input held the last slot
module adc_lane_deserializer import adc_capture_pkg::*; (
  input  wire logic      adc_clk,
  input  wire logic      dcm_reset,
  input  wire adc_pins_s pin_sample,  // registered pins
  input  wire logic      pin_valid,   // high from the first sample after reset
  output adc_word_s      word,
  output logic           word_valid
);

  localparam slot_idx_t SLOT_LAST = slot_idx_t'(SLOTS_PER_WORD - 1);

  slot_idx_t slot;        // slot the current pin sample goes into
  adc_word_s hold_word;   // partially filled word
  adc_word_s next_word;   // hold_word with the current sample merged in
  logic      last_slot;   // current sample completes the word
  logic      ovr_half;    // which overrange flag this slot feeds

  // --------------------------------------------------
  // merge helpers
  // --------------------------------------------------

  // drop one sample into its byte of a lane group
  function automatic lane_group_t put_sample(
    lane_group_t group,
    slot_idx_t   slot_idx,
    sample_t     value
  );
    lane_group_t res;
    res = group;
    res[slot_idx*SAMPLE_W +: SAMPLE_W] = value;
    return res;
  endfunction

  assign last_slot = (slot == SLOT_LAST);
  assign ovr_half  = slot[SLOT_W-1];  // top slot bit picks the half

  always_comb begin
    next_word = hold_word;

    // each lane into its slot byte
    next_word.di_d = put_sample(hold_word.di_d, slot, pin_sample.di_d);
    next_word.di   = put_sample(hold_word.di,   slot, pin_sample.di);
    next_word.dq_d = put_sample(hold_word.dq_d, slot, pin_sample.dq_d);
    next_word.dq   = put_sample(hold_word.dq,   slot, pin_sample.dq);

    next_word.sync[slot] = pin_sample.sync;  // every slot overwrites its own bit

    // overrange is sticky within a word
    if (slot == '0) begin
      next_word.overrange = '0;  // fresh word
    end
    next_word.overrange[ovr_half] = next_word.overrange[ovr_half] | pin_sample.overrange;
  end

  // --------------------------------------------------
  // slot counter and word strobe
  // --------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      slot       <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= pin_valid & last_slot;  // one cycle per word
      if (pin_valid) begin
        slot <= slot + 1'b1;  // wraps after the last slot
      end
    end
  end

  // payload, no reset
  always_ff @(posedge adc_clk) begin
    if (pin_valid) begin
      hold_word <= next_word;
    end
  end

  // completed word held until the next one is done
  always_ff @(posedge adc_clk) begin
    if (pin_valid && last_slot) begin
      word <= next_word;
    end
  end

endmodule

`default_nettype wire

/* adc_capture_pkg.sv */
`default_nettype none

package adc_capture_pkg;

  // --------------------------------------------------
  // sample and word geometry
  // --------------------------------------------------

  localparam int SAMPLE_W       = 8;   // one adc sample
  localparam int SLOTS_PER_WORD = 4;   // samples per lane in one word
  localparam int SLOT_W         = 2;   // slot counter width
  localparam int OVR_HALVES     = 2;   // overrange flags per word

  // --------------------------------------------------
  // word fifo
  // --------------------------------------------------

  localparam int FIFO_DEPTH  = 16;     // words held
  localparam int FIFO_ADDR_W = 4;      // pointer width, depth is a power of two

  // one sample of one lane
  typedef logic [SAMPLE_W-1:0] sample_t;

  // four samples of one lane, slot 0 (oldest) in the low byte
  typedef logic [SLOTS_PER_WORD*SAMPLE_W-1:0] lane_group_t;

  // sync pin per slot, slot 0 in bit 0
  typedef logic [SLOTS_PER_WORD-1:0] sync_slots_t;

  // bit 0 covers slots 0/1, bit 1 covers slots 2/3
  typedef logic [OVR_HALVES-1:0] overrange_t;

  typedef logic [SLOT_W-1:0]      slot_idx_t;    // position inside a word
  typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;   // fifo read/write pointer
  typedef logic [FIFO_ADDR_W:0]   fifo_count_t;  // 0 .. FIFO_DEPTH

  // one cycle of pins, 34 bits
  typedef struct packed {
    sample_t di_d;
    sample_t di;
    sample_t dq_d;
    sample_t dq;
    logic    sync;
    logic    overrange;
  } adc_pins_s;

  // one output word, 134 bits
  // same bit layout as the old fifo word: sync on top, di_d at the bottom
  typedef struct packed {
    sync_slots_t sync;       // [133:130]
    overrange_t  overrange;  // [129:128]
    lane_group_t dq;         // [127:96]
    lane_group_t dq_d;       // [95:64]
    lane_group_t di;         // [63:32]
    lane_group_t di_d;       // [31:0]
  } adc_word_s;

endpackage

`default_nettype wire
